//--- design/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path width of the core
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Bits needed to name one register
`define REG_IDX_W 5

`endif

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the RV32I base set
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // Shared by ecall, ebreak and the CSR instructions
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 codes of the immediate shifts
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_srl_sra = 3'b101;

    // funct3 of ecall and ebreak
    localparam logic [2:0] f3_priv = 3'b000;

    // Encodings of the immediate formats
    typedef enum logic [2:0] {
        imm_i     = 3'b000,
        imm_b     = 3'b001,
        imm_s     = 3'b010,
        imm_u     = 3'b011,
        imm_j     = 3'b100,
        imm_shamt = 3'b101,
        imm_none  = 3'b111
    } imm_type_e;

endpackage

`default_nettype wire

//--- design/id_pipe_pkg.sv
`default_nettype none

`include "core_macros.svh"

package id_pipe_pkg;

    // Control half of the ID/EX register
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [11:0]           csr_addr;
        // Active-low write enables
        logic                  wr_reg_n;
        logic                  wr_csr_n;
    } id_ctrl_t;

    // Operand half of the ID/EX register
    typedef struct packed {
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm;
    } id_data_t;

endpackage

`default_nettype wire

//--- design/id_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module id_control
    import rv_isa_pkg::*;
(
    input  wire logic [`XLEN-1:0]     ir,
    output logic      [`REG_IDX_W-1:0] rs1,
    output logic      [`REG_IDX_W-1:0] rs2,
    output logic      [`REG_IDX_W-1:0] rd,
    output logic      [6:0]            opcode,
    output logic      [2:0]            funct3,
    output logic      [6:0]            funct7,
    output logic      [11:0]           csr_addr,
    output imm_type_e                  imm_type,
    output logic                       wr_reg_n,
    output logic                       wr_csr_n
);

    logic writes_rd;

    // Fixed RV32I field positions
    assign opcode   = ir[6:0];
    assign rd       = ir[11:7];
    assign funct3   = ir[14:12];
    assign rs1      = ir[19:15];
    assign rs2      = ir[24:20];
    assign funct7   = ir[31:25];
    assign csr_addr = ir[31:20];

    // Immediate format by opcode
    always_comb begin
        case (opcode)
            op_lui,
            op_auipc:  imm_type = imm_u;
            op_jal:    imm_type = imm_j;
            op_jalr,
            op_load:   imm_type = imm_i;
            op_branch: imm_type = imm_b;
            op_store:  imm_type = imm_s;
            op_imm: begin
                // slli, srli and srai carry a shift amount instead
                if (funct3 == f3_sll || funct3 == f3_srl_sra) begin
                    imm_type = imm_shamt;
                end else begin
                    imm_type = imm_i;
                end
            end
            default:   imm_type = imm_none;
        endcase
    end

    // Whitelist of opcodes that produce a register result
    always_comb begin
        case (opcode)
            op_lui,
            op_auipc,
            op_imm,
            op_reg,
            op_load,
            op_jal,
            op_jalr: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    // Writes to x0 are dropped here already
    assign wr_reg_n = !(writes_rd && (rd != '0));

    // ecall and ebreak share the system opcode but have funct3 of zero
    assign wr_csr_n = !((opcode == op_system) && (funct3 != f3_priv));

    // Any known word must map to a known format, none included
    imm_type_known: assert property (
        @(ir) !$isunknown(ir) |-> !$isunknown(imm_type)
    );

endmodule

`default_nettype wire

//--- design/imm_extractor.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module imm_extractor
    import rv_isa_pkg::*;
(
    input  wire logic [`XLEN-1:0] ir,
    input  wire imm_type_e        imm_type,
    output logic      [`XLEN-1:0] imm
);

    logic sign;

    // Bit 31 is the sign for every signed format
    assign sign = ir[31];

    always_comb begin
        case (imm_type)
            imm_i: begin
                imm = {{(`XLEN-12){sign}}, ir[31:20]};
            end
            imm_s: begin
                imm = {{(`XLEN-12){sign}}, ir[31:25], ir[11:7]};
            end
            imm_b: begin
                // Branch offsets are in half words
                imm = {{(`XLEN-13){sign}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            imm_u: begin
                imm = {ir[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(`XLEN-21){sign}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            imm_shamt: begin
                // Unsigned shift amount without the funct7 bits
                imm = {{(`XLEN-5){1'b0}}, ir[24:20]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [`REG_IDX_W-1:0] rs1,
    input  wire logic [`REG_IDX_W-1:0] rs2,
    output logic      [`XLEN-1:0]      rs1_data,
    output logic      [`XLEN-1:0]      rs2_data,
    input  wire logic                  wb_we,
    input  wire logic [`REG_IDX_W-1:0] wb_rd,
    input  wire logic [`XLEN-1:0]      wb_data
);

    // No storage behind x0
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    // x0 rule first, then write-first bypass, then storage
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end else if (wb_we && (wb_rd == idx)) begin
            return wb_data;
        end else begin
            return regs[idx];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-back to x0 must never leak through the bypass
    rs1_x0_zero: assert property (
        @(posedge clk) disable iff (reset) (rs1 == '0) |-> (rs1_data == '0)
    );

    rs2_x0_zero: assert property (
        @(posedge clk) disable iff (reset) (rs2 == '0) |-> (rs2_data == '0)
    );

endmodule

`default_nettype wire

//--- design/id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_ex_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     in_valid,
    input  wire logic     stall,
    input  wire logic     flush,
    input  wire payload_t in_payload,
    input  wire payload_t reset_payload,
    output logic          out_valid,
    output payload_t      out_payload
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid   <= 1'b0;
            out_payload <= reset_payload;
        end else if (flush) begin
            // Flush wins over stall and leaves the payload alone
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
            // Only accepted instructions replace the payload
            if (in_valid) begin
                out_payload <= in_payload;
            end
        end
    end

    // A flushed slot never shows up as valid
    flush_kills_valid: assert property (
        @(posedge clk) disable iff (reset) flush |=> !out_valid
    );

endmodule

`default_nettype wire

//--- design/id_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module id_stage
    import rv_isa_pkg::*, id_pipe_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic [`XLEN-1:0]      ir,
    input  wire logic                  ir_valid,
    input  wire logic                  stall,
    input  wire logic                  flush,
    input  wire logic                  wb_we,
    input  wire logic [`REG_IDX_W-1:0] wb_rd,
    input  wire logic [`XLEN-1:0]      wb_data,
    output logic                       ex_valid,
    output logic      [`REG_IDX_W-1:0] ex_rd,
    output logic      [6:0]            ex_opcode,
    output logic      [2:0]            ex_funct3,
    output logic      [6:0]            ex_funct7,
    output logic      [11:0]           ex_csr_addr,
    output logic      [`XLEN-1:0]      ex_imm,
    output logic      [`XLEN-1:0]      ex_rs1_data,
    output logic      [`XLEN-1:0]      ex_rs2_data,
    output logic                       ex_wr_reg_n,
    output logic                       ex_wr_csr_n
);

    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    imm_type_e             imm_type;
    id_ctrl_t              ctrl_in;
    id_ctrl_t              ctrl_out;
    id_ctrl_t              ctrl_reset;
    id_data_t              data_in;
    id_data_t              data_out;

    id_control id_control_inst (
        .ir       (ir),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (ctrl_in.rd),
        .opcode   (ctrl_in.opcode),
        .funct3   (ctrl_in.funct3),
        .funct7   (ctrl_in.funct7),
        .csr_addr (ctrl_in.csr_addr),
        .imm_type (imm_type),
        .wr_reg_n (ctrl_in.wr_reg_n),
        .wr_csr_n (ctrl_in.wr_csr_n)
    );

    imm_extractor imm_extractor_inst (
        .ir       (ir),
        .imm_type (imm_type),
        .imm      (data_in.imm)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (data_in.rs1_data),
        .rs2_data (data_in.rs2_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    // Both write enables inactive out of reset
    assign ctrl_reset = '{wr_reg_n: 1'b1, wr_csr_n: 1'b1, default: '0};

    id_ex_reg #(.payload_t(id_ctrl_t)) ctrl_reg_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (ir_valid),
        .stall         (stall),
        .flush         (flush),
        .in_payload    (ctrl_in),
        .reset_payload (ctrl_reset),
        .out_valid     (ex_valid),
        .out_payload   (ctrl_out)
    );

    // Valid of this copy tracks the control one and stays open
    id_ex_reg #(.payload_t(id_data_t)) data_reg_inst (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (ir_valid),
        .stall         (stall),
        .flush         (flush),
        .in_payload    (data_in),
        .reset_payload ('0),
        .out_valid     (),
        .out_payload   (data_out)
    );

    assign ex_rd       = ctrl_out.rd;
    assign ex_opcode   = ctrl_out.opcode;
    assign ex_funct3   = ctrl_out.funct3;
    assign ex_funct7   = ctrl_out.funct7;
    assign ex_csr_addr = ctrl_out.csr_addr;
    assign ex_wr_reg_n = ctrl_out.wr_reg_n;
    assign ex_wr_csr_n = ctrl_out.wr_csr_n;
    assign ex_imm      = data_out.imm;
    assign ex_rs1_data = data_out.rs1_data;
    assign ex_rs2_data = data_out.rs2_data;

endmodule

`default_nettype wire

//--- dv/id_model.svh
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// Architectural registers as seen through the write-back port
logic [`XLEN-1:0] shadow_regs [0:`REG_COUNT-1];

// Immediate straight from the RV32I encoding tables
function automatic logic [`XLEN-1:0] expected_imm(input logic [`XLEN-1:0] word);
    logic [`XLEN-1:0] value;
    logic [2:0]       f3;
    f3 = word[14:12];
    case (word[6:0])
        op_lui, op_auipc: value = {word[31:12], 12'h000};
        op_jal: value = {{(`XLEN-20){word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        op_jalr, op_load: value = {{(`XLEN-12){word[31]}}, word[31:20]};
        op_branch: value = {{(`XLEN-12){word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        op_store: value = {{(`XLEN-12){word[31]}}, word[31:25], word[11:7]};
        op_imm: begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                value = {{(`XLEN-5){1'b0}}, word[24:20]};
            end else begin
                value = {{(`XLEN-12){word[31]}}, word[31:20]};
            end
        end
        default: value = '0;
    endcase
    return value;
endfunction

// Low only for result-producing opcodes with rd other than x0
function automatic logic expected_wr_reg_n(input logic [`XLEN-1:0] word);
    logic has_result;
    has_result = (word[6:0] == op_lui) || (word[6:0] == op_auipc) ||
                 (word[6:0] == op_imm) || (word[6:0] == op_reg) ||
                 (word[6:0] == op_load) || (word[6:0] == op_jal) ||
                 (word[6:0] == op_jalr);
    return !(has_result && (word[11:7] != 5'd0));
endfunction

// ecall and ebreak have funct3 zero and touch no CSR
function automatic logic expected_wr_csr_n(input logic [`XLEN-1:0] word);
    return !((word[6:0] == op_system) && (word[14:12] != 3'b000));
endfunction

function automatic void shadow_clear();
    for (int i = 0; i < `REG_COUNT; i++) begin
        shadow_regs[i] = '0;
    end
endfunction

function automatic void shadow_write(
    input logic                  we,
    input logic [`REG_IDX_W-1:0] idx,
    input logic [`XLEN-1:0]      value
);
    if (we && (idx != '0)) begin
        shadow_regs[idx] = value;
    end
endfunction

// Same-cycle write-back wins over the stored value
function automatic logic [`XLEN-1:0] shadow_read(
    input logic [`REG_IDX_W-1:0] idx,
    input logic                  we,
    input logic [`REG_IDX_W-1:0] wb_idx,
    input logic [`XLEN-1:0]      wb_value
);
    if (idx == '0) begin
        return '0;
    end
    if (we && (wb_idx == idx)) begin
        return wb_value;
    end
    return shadow_regs[idx];
endfunction

`endif

//--- dv/id_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module id_stage_tb
    import rv_isa_pkg::*, id_pipe_pkg::*;
();

    `include "id_model.svh"

    localparam int num_cycles = 1500;

    logic                  clk;
    logic                  reset;
    logic [`XLEN-1:0]      ir;
    logic                  ir_valid;
    logic                  stall;
    logic                  flush;
    logic                  wb_we;
    logic [`REG_IDX_W-1:0] wb_rd;
    logic [`XLEN-1:0]      wb_data;
    logic                  ex_valid;
    logic [`REG_IDX_W-1:0] ex_rd;
    logic [6:0]            ex_opcode;
    logic [2:0]            ex_funct3;
    logic [6:0]            ex_funct7;
    logic [11:0]           ex_csr_addr;
    logic [`XLEN-1:0]      ex_imm;
    logic [`XLEN-1:0]      ex_rs1_data;
    logic [`XLEN-1:0]      ex_rs2_data;
    logic                  ex_wr_reg_n;
    logic                  ex_wr_csr_n;

    // Inputs in flight this cycle and the EX state they lead to
    logic     cur_valid;
    logic     cur_stall;
    logic     cur_flush;
    id_ctrl_t cur_ctrl;
    id_data_t cur_data;
    logic     exp_valid;
    id_ctrl_t exp_ctrl;
    id_data_t exp_data;
    logic     checking;
    int       checks;
    int       errors;
    int       timeouts;

    id_stage id_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %s at %0t: expected %h, actual %h", name, $time, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        check_value("ex_valid", 32'(exp_valid), 32'(ex_valid));
        check_value("ex_rd", 32'(exp_ctrl.rd), 32'(ex_rd));
        check_value("ex_opcode", 32'(exp_ctrl.opcode), 32'(ex_opcode));
        check_value("ex_funct3", 32'(exp_ctrl.funct3), 32'(ex_funct3));
        check_value("ex_funct7", 32'(exp_ctrl.funct7), 32'(ex_funct7));
        check_value("ex_csr_addr", 32'(exp_ctrl.csr_addr), 32'(ex_csr_addr));
        check_value("ex_wr_reg_n", 32'(exp_ctrl.wr_reg_n), 32'(ex_wr_reg_n));
        check_value("ex_wr_csr_n", 32'(exp_ctrl.wr_csr_n), 32'(ex_wr_csr_n));
        check_value("ex_imm", exp_data.imm, ex_imm);
        check_value("ex_rs1_data", exp_data.rs1_data, ex_rs1_data);
        check_value("ex_rs2_data", exp_data.rs2_data, ex_rs2_data);
    endtask

    // Flush beats stall and keeps the payload while stall holds everything
    function automatic void apply_edge();
        if (cur_flush) begin
            exp_valid = 1'b0;
        end else if (!cur_stall) begin
            exp_valid = cur_valid;
            if (cur_valid) begin
                exp_ctrl = cur_ctrl;
                exp_data = cur_data;
            end
        end
    endfunction

    task automatic drive_cycle(
        input logic                  valid_in,
        input logic [`XLEN-1:0]      word,
        input logic                  stall_in,
        input logic                  flush_in,
        input logic                  we_in,
        input logic [`REG_IDX_W-1:0] rd_in,
        input logic [`XLEN-1:0]      data_in
    );
        @(posedge clk);
        apply_edge();
        cur_valid = valid_in;
        cur_stall = stall_in;
        cur_flush = flush_in;
        cur_ctrl.rd = word[11:7];
        cur_ctrl.opcode = word[6:0];
        cur_ctrl.funct3 = word[14:12];
        cur_ctrl.funct7 = word[31:25];
        cur_ctrl.csr_addr = word[31:20];
        cur_ctrl.wr_reg_n = expected_wr_reg_n(word);
        cur_ctrl.wr_csr_n = expected_wr_csr_n(word);
        cur_data.imm = expected_imm(word);
        cur_data.rs1_data = shadow_read(word[19:15], we_in, rd_in, data_in);
        cur_data.rs2_data = shadow_read(word[24:20], we_in, rd_in, data_in);
        // Storage sees the write at the coming edge
        shadow_write(we_in, rd_in, data_in);
        ir <= word;
        ir_valid <= valid_in;
        stall <= stall_in;
        flush <= flush_in;
        wb_we <= we_in;
        wb_rd <= rd_in;
        wb_data <= data_in;
    endtask

    function automatic logic [`XLEN-1:0] random_instr();
        logic [`XLEN-1:0] word;
        logic [6:0]       opc;
        word = $urandom;
        case ($urandom_range(0, 11))
            0: opc = op_lui;
            1: opc = op_auipc;
            2: opc = op_jal;
            3: opc = op_jalr;
            4: opc = op_branch;
            5: opc = op_load;
            6: opc = op_store;
            7: opc = op_imm;
            8: opc = op_reg;
            9: opc = op_system;
            // Low bits other than 11 are never a 32-bit opcode
            default: opc = {5'($urandom), 2'($urandom_range(0, 2))};
        endcase
        word[6:0] = opc;
        // ecall and ebreak often enough
        if (opc == op_system && $urandom_range(0, 1) == 0) begin
            word[14:12] = 3'b000;
        end
        if ($urandom_range(0, 7) == 0) begin
            word[11:7] = 5'd0;
        end
        return word;
    endfunction

    task automatic random_cycle();
        logic [`XLEN-1:0]      word;
        logic [`REG_IDX_W-1:0] wb_idx;
        word = random_instr();
        case ($urandom_range(0, 7))
            0, 1: wb_idx = word[19:15];
            2: wb_idx = word[24:20];
            3: wb_idx = '0;
            default: wb_idx = 5'($urandom);
        endcase
        drive_cycle($urandom_range(0, 5) != 0, word, $urandom_range(0, 4) == 0,
                    $urandom_range(0, 9) == 0, $urandom_range(0, 3) != 0, wb_idx, $urandom);
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // Outputs settle well before the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (checking) begin
                compare_outputs();
            end
        end
    end

    initial begin
        int   waited;
        logic seen;
        void'($urandom(64));
        reset = 1'b1;
        ir = '0;
        ir_valid = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        cur_valid = 1'b0;
        cur_stall = 1'b0;
        cur_flush = 1'b0;
        cur_ctrl = '0;
        cur_data = '0;
        exp_valid = 1'b0;
        exp_ctrl = '{wr_reg_n: 1'b1, wr_csr_n: 1'b1, default: '0};
        exp_data = '0;
        checking = 1'b0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        shadow_clear();

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        checking = 1'b1;

        // Idle cycles after reset where nothing may look like a write
        repeat (4) drive_cycle(1'b0, $urandom, 1'b0, 1'b0, 1'b0, '0, '0);

        drive_cycle(1'b1, random_instr(), 1'b0, 1'b0, 1'b0, '0, '0);
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < 8) begin
            drive_cycle(1'b0, $urandom, 1'b0, 1'b0, 1'b0, '0, '0);
            @(negedge clk);
            seen = ex_valid;
            waited++;
        end
        if (!seen) begin
            $display("Timeout: the first valid instruction never reached the EX outputs");
            timeouts++;
            @(posedge clk);
            finish_run();
        end

        // x0 next to a write-back to x0, then a same-cycle bypass on x5
        drive_cycle(1'b1, {12'h123, 5'd0, 3'b000, 5'd1, op_imm}, 1'b0, 1'b0,
                    1'b1, 5'd0, 32'hdead_beef);
        drive_cycle(1'b1, {7'd0, 5'd5, 5'd5, 3'b000, 5'd2, op_reg}, 1'b0, 1'b0,
                    1'b1, 5'd5, 32'h1234_5678);
        // Flush together with stall, then a plain stall
        drive_cycle(1'b1, random_instr(), 1'b1, 1'b1, 1'b0, '0, '0);
        drive_cycle(1'b1, random_instr(), 1'b1, 1'b0, 1'b0, '0, '0);

        repeat (num_cycles) random_cycle();

        drive_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
+incdir+dv
design/rv_isa_pkg.sv
design/id_pipe_pkg.sv
design/id_control.sv
design/imm_extractor.sv
design/reg_file.sv
design/id_ex_reg.sv
design/id_stage.sv
dv/id_stage_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := id_stage_tb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run counts as passed only if the pass line shows up in the log
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
